// File: panel_ctrl_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// panel geometry and brightness depth
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PANEL_CTRL_CONSTS_SVH
`define PANEL_CTRL_CONSTS_SVH

// framebuffer address fields
`define PANEL_ROW_BITS 4
`define PANEL_COL_BITS 5
`define PANEL_PIXEL_BITS 1

// every address of the panel, swept by blank and fill
`define PANEL_ADDR_COUNT 1024

// brightness bits, msb is brightness one
`define BRIGHTNESS_LEVELS 8

`endif

// File: panel_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// panel data types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "panel_ctrl_consts.svh"

package panel_pkg;

    // counts up as one flat number
    typedef struct packed {
        logic [`PANEL_ROW_BITS-1:0]   row;
        logic [`PANEL_COL_BITS-1:0]   col;
        logic [`PANEL_PIXEL_BITS-1:0] pixel;
    } fb_addr_t;

    typedef logic [7:0] pixel_data_t;
    typedef logic [`BRIGHTNESS_LEVELS-1:0] brightness_t;
    typedef logic [7:0] cmd_byte_t;

endpackage

// File: cmd_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command opcodes and sequencer states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cmd_pkg;

    typedef enum logic [7:0] {
        RED_ENABLE       = 8'h10,
        RED_DISABLE      = 8'h11,
        GREEN_ENABLE     = 8'h12,
        GREEN_DISABLE    = 8'h13,
        BLUE_ENABLE      = 8'h14,
        BLUE_DISABLE     = 8'h15,
        BRIGHTNESS_ZERO  = 8'h20,
        BRIGHTNESS_ONE   = 8'h21,
        BRIGHTNESS_TWO   = 8'h22,
        BRIGHTNESS_THREE = 8'h23,
        BRIGHTNESS_FOUR  = 8'h24,
        BRIGHTNESS_FIVE  = 8'h25,
        BRIGHTNESS_SIX   = 8'h26,
        BRIGHTNESS_SEVEN = 8'h27,
        BRIGHTNESS_EIGHT = 8'h28,
        BRIGHTNESS_NINE  = 8'h29,
        READBRIGHTNESS   = 8'h30,
        BLANKPANEL       = 8'h40,
        FILLPANEL        = 8'h41
    } opcode_t;

    // waiting for an argument byte, or sweeping the framebuffer
    typedef enum logic [1:0] {
        IDLE,
        BRIGHTNESS_ARG,
        FILL_ARG,
        SWEEP
    } seq_state_t;

endpackage

// File: cmd_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command sequencer FSM, byte acceptance,
// start strobes, busy and ready_for_data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cmd_sequencer (
    input  logic                 clk_in,
    input  logic                 reset,
    input  panel_pkg::cmd_byte_t data_rx,
    input  logic                 data_ready_n,
    input  logic                 sweep_done,
    output logic                 opcode_strobe,
    output logic                 brightness_strobe,
    output logic                 blank_start,
    output logic                 fill_start,
    output logic                 busy,
    output logic                 ready_for_data
);

    cmd_pkg::seq_state_t state;
    cmd_pkg::opcode_t opcode;
    logic accept;

    assign opcode = cmd_pkg::opcode_t'(data_rx);

    // bytes are only refused while the sweep runs
    assign ready_for_data = (state != cmd_pkg::SWEEP);
    assign busy = (state != cmd_pkg::IDLE);
    assign accept = ~data_ready_n && ready_for_data;

    assign opcode_strobe = accept && (state == cmd_pkg::IDLE);
    assign blank_start = opcode_strobe && (opcode == cmd_pkg::BLANKPANEL);
    assign brightness_strobe = accept && (state == cmd_pkg::BRIGHTNESS_ARG);
    // argument byte is the fill colour
    assign fill_start = accept && (state == cmd_pkg::FILL_ARG);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= cmd_pkg::IDLE;
        end else begin
            case (state)
                cmd_pkg::IDLE: begin
                    if (opcode_strobe) begin
                        // settings and unknown opcodes stay in idle
                        case (opcode)
                            cmd_pkg::READBRIGHTNESS: begin
                                state <= cmd_pkg::BRIGHTNESS_ARG;
                            end
                            cmd_pkg::BLANKPANEL: begin
                                state <= cmd_pkg::SWEEP;
                            end
                            cmd_pkg::FILLPANEL: begin
                                state <= cmd_pkg::FILL_ARG;
                            end
                            default: begin
                                state <= cmd_pkg::IDLE;
                            end
                        endcase
                    end
                end
                cmd_pkg::BRIGHTNESS_ARG: begin
                    if (brightness_strobe) begin
                        state <= cmd_pkg::IDLE;
                    end
                end
                cmd_pkg::FILL_ARG: begin
                    if (fill_start) begin
                        state <= cmd_pkg::SWEEP;
                    end
                end
                cmd_pkg::SWEEP: begin
                    // leave on the edge that ends the last write
                    if (sweep_done) begin
                        state <= cmd_pkg::IDLE;
                    end
                end
                default: begin
                    state <= cmd_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

// File: settings_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// colour enable and brightness registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "panel_ctrl_consts.svh"

module settings_regs (
    input  logic                   clk_in,
    input  logic                   reset,
    input  panel_pkg::cmd_byte_t   data_rx,
    input  logic                   opcode_strobe,
    input  logic                   brightness_strobe,
    output logic [2:0]             rgb_enable,
    output panel_pkg::brightness_t brightness_level
);

    panel_pkg::brightness_t toggle_mask;
    logic [3:0] level_sel;

    // brightness one..eight map to 1..8 in the low nibble
    assign level_sel = data_rx[3:0];
    // level one is the msb
    assign toggle_mask = panel_pkg::brightness_t'(1) << (`BRIGHTNESS_LEVELS - level_sel);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb_enable <= 3'b111;
            brightness_level <= '1;
        end else if (brightness_strobe) begin
            brightness_level <= data_rx;
        end else if (opcode_strobe) begin
            case (cmd_pkg::opcode_t'(data_rx))
                cmd_pkg::RED_ENABLE:    rgb_enable[0] <= 1'b1;
                cmd_pkg::RED_DISABLE:   rgb_enable[0] <= 1'b0;
                cmd_pkg::GREEN_ENABLE:  rgb_enable[1] <= 1'b1;
                cmd_pkg::GREEN_DISABLE: rgb_enable[1] <= 1'b0;
                cmd_pkg::BLUE_ENABLE:   rgb_enable[2] <= 1'b1;
                cmd_pkg::BLUE_DISABLE:  rgb_enable[2] <= 1'b0;
                cmd_pkg::BRIGHTNESS_ONE, cmd_pkg::BRIGHTNESS_TWO,
                cmd_pkg::BRIGHTNESS_THREE, cmd_pkg::BRIGHTNESS_FOUR,
                cmd_pkg::BRIGHTNESS_FIVE, cmd_pkg::BRIGHTNESS_SIX,
                cmd_pkg::BRIGHTNESS_SEVEN, cmd_pkg::BRIGHTNESS_EIGHT: begin
                    brightness_level <= brightness_level ^ toggle_mask;
                end
                cmd_pkg::BRIGHTNESS_ZERO: brightness_level <= '0;
                cmd_pkg::BRIGHTNESS_NINE: brightness_level <= '1;
                // sequencer opcodes and unknown bytes
                default: ;
            endcase
        end
    end

endmodule

// File: panel_fill.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// framebuffer sweep for blank and fill
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "panel_ctrl_consts.svh"

module panel_fill (
    input  logic                   clk_in,
    input  logic                   reset,
    input  panel_pkg::cmd_byte_t   data_rx,
    input  logic                   blank_start,
    input  logic                   fill_start,
    output panel_pkg::fb_addr_t    ram_address,
    output panel_pkg::pixel_data_t ram_data,
    output logic                   ram_write_enable,
    output logic                   sweep_done
);

    localparam int ADDR_BITS = $bits(panel_pkg::fb_addr_t);
    localparam logic [ADDR_BITS-1:0] LAST_ADDR = ADDR_BITS'(`PANEL_ADDR_COUNT - 1);

    logic [ADDR_BITS-1:0] addr_count;
    logic active;

    assign ram_address = panel_pkg::fb_addr_t'(addr_count);
    assign ram_write_enable = active;
    assign sweep_done = active && (addr_count == LAST_ADDR);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            active <= 1'b0;
            addr_count <= '0;
        end else if (blank_start || fill_start) begin
            active <= 1'b1;
            addr_count <= '0;
        end else if (active) begin
            // one address per cycle, stop after the last
            active <= ~sweep_done;
            addr_count <= addr_count + 1'b1;
        end
    end

    // colour held for the whole sweep
    always_ff @(posedge clk_in) begin
        if (blank_start) begin
            ram_data <= '0;
        end else if (fill_start) begin
            ram_data <= data_rx;
        end
    end

endmodule

// File: panel_ctrl_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LED panel command front end, top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module panel_ctrl_top (
    input  logic                   clk_in,
    input  logic                   reset,
    input  panel_pkg::cmd_byte_t   data_rx,
    input  logic                   data_ready_n,
    output logic [2:0]             rgb_enable,
    output panel_pkg::brightness_t brightness_level,
    output panel_pkg::fb_addr_t    ram_address,
    output panel_pkg::pixel_data_t ram_data,
    output logic                   ram_write_enable,
    output logic                   busy,
    output logic                   ready_for_data
);

    logic opcode_strobe;
    logic brightness_strobe;
    logic blank_start;
    logic fill_start;
    logic sweep_done;

    cmd_sequencer sequencer_i (
        .clk_in            (clk_in),
        .reset             (reset),
        .data_rx           (data_rx),
        .data_ready_n      (data_ready_n),
        .sweep_done        (sweep_done),
        .opcode_strobe     (opcode_strobe),
        .brightness_strobe (brightness_strobe),
        .blank_start       (blank_start),
        .fill_start        (fill_start),
        .busy              (busy),
        .ready_for_data    (ready_for_data)
    );

    settings_regs settings_i (
        .clk_in            (clk_in),
        .reset             (reset),
        .data_rx           (data_rx),
        .opcode_strobe     (opcode_strobe),
        .brightness_strobe (brightness_strobe),
        .rgb_enable        (rgb_enable),
        .brightness_level  (brightness_level)
    );

    // sweep engine runs beside the settings registers
    panel_fill fill_i (
        .clk_in           (clk_in),
        .reset            (reset),
        .data_rx          (data_rx),
        .blank_start      (blank_start),
        .fill_start       (fill_start),
        .ram_address      (ram_address),
        .ram_data         (ram_data),
        .ram_write_enable (ram_write_enable),
        .sweep_done       (sweep_done)
    );

endmodule

// File: panel_ctrl_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model and bound assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "panel_ctrl_consts.svh"

module panel_ctrl_checker (
    input logic                   clk_in,
    input logic                   reset,
    input panel_pkg::cmd_byte_t   data_rx,
    input logic                   data_ready_n,
    input logic [2:0]             rgb_enable,
    input panel_pkg::brightness_t brightness_level,
    input panel_pkg::fb_addr_t    ram_address,
    input panel_pkg::pixel_data_t ram_data,
    input logic                   ram_write_enable,
    input logic                   busy,
    input logic                   ready_for_data
);

    localparam int LAST_ADDR = `PANEL_ADDR_COUNT - 1;

    cmd_pkg::seq_state_t m_state;
    logic [2:0] exp_rgb;
    panel_pkg::brightness_t exp_bright;
    panel_pkg::pixel_data_t exp_data;
    panel_pkg::fb_addr_t exp_addr;
    logic accept;
    int bit_index;
    int sweep_count;
    int error_count = 0;

    // the panel refuses bytes only while sweeping
    assign accept = !data_ready_n && (m_state != cmd_pkg::SWEEP);
    // brightness n flips bit LEVELS-n
    assign bit_index = `BRIGHTNESS_LEVELS - int'(data_rx[3:0]);

    always @(posedge clk_in) begin
        if (reset) begin
            m_state <= cmd_pkg::IDLE;
            exp_rgb <= 3'b111;
            exp_bright <= '1;
            exp_data <= '0;
            exp_addr <= '0;
            sweep_count <= 0;
        end else if (m_state == cmd_pkg::SWEEP) begin
            // wraps back to zero after the last address
            exp_addr <= exp_addr + 1'b1;
            if (int'(exp_addr) == LAST_ADDR) begin
                m_state <= cmd_pkg::IDLE;
                sweep_count <= sweep_count + 1;
            end
        end else if (accept && m_state == cmd_pkg::BRIGHTNESS_ARG) begin
            exp_bright <= data_rx;
            m_state <= cmd_pkg::IDLE;
        end else if (accept && m_state == cmd_pkg::FILL_ARG) begin
            exp_data <= data_rx;
            m_state <= cmd_pkg::SWEEP;
        end else if (accept) begin
            case (data_rx) inside
                cmd_pkg::RED_ENABLE:    exp_rgb[0] <= 1'b1;
                cmd_pkg::RED_DISABLE:   exp_rgb[0] <= 1'b0;
                cmd_pkg::GREEN_ENABLE:  exp_rgb[1] <= 1'b1;
                cmd_pkg::GREEN_DISABLE: exp_rgb[1] <= 1'b0;
                cmd_pkg::BLUE_ENABLE:   exp_rgb[2] <= 1'b1;
                cmd_pkg::BLUE_DISABLE:  exp_rgb[2] <= 1'b0;
                [cmd_pkg::BRIGHTNESS_ONE:cmd_pkg::BRIGHTNESS_EIGHT]: begin
                    exp_bright[bit_index] <= ~exp_bright[bit_index];
                end
                cmd_pkg::BRIGHTNESS_ZERO: exp_bright <= '0;
                cmd_pkg::BRIGHTNESS_NINE: exp_bright <= '1;
                cmd_pkg::READBRIGHTNESS:  m_state <= cmd_pkg::BRIGHTNESS_ARG;
                cmd_pkg::FILLPANEL:       m_state <= cmd_pkg::FILL_ARG;
                cmd_pkg::BLANKPANEL: begin
                    exp_data <= '0;
                    m_state <= cmd_pkg::SWEEP;
                end
                default: ;
            endcase
        end
    end

    a_settings: assert property (@(posedge clk_in) disable iff (reset)
            rgb_enable == exp_rgb && brightness_level == exp_bright)
        else begin
            error_count++;
            $error("Error %0t: rgb_enable or brightness_level differs from the model", $time);
        end
    a_flags: assert property (@(posedge clk_in) disable iff (reset)
            busy == (m_state != cmd_pkg::IDLE) && ready_for_data == (m_state != cmd_pkg::SWEEP))
        else begin
            error_count++;
            $error("Error %0t: busy or ready_for_data wrong for the model state", $time);
        end
    a_write_window: assert property (@(posedge clk_in) disable iff (reset)
            ram_write_enable == (m_state == cmd_pkg::SWEEP))
        else begin
            error_count++;
            $error("Error %0t: ram_write_enable outside the sweep window", $time);
        end
    a_write_target: assert property (@(posedge clk_in) disable iff (reset)
            ram_write_enable |-> ram_address == exp_addr && ram_data == exp_data)
        else begin
            error_count++;
            $error("Error %0t: ram_address or ram_data wrong during the sweep", $time);
        end

endmodule

bind panel_ctrl_top panel_ctrl_checker checker_i (.*);

// File: tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_clock_gen #(
    parameter int PERIOD = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_in,
    output logic reset
);

    initial begin
        clk_in = 1'b0;
        forever #(PERIOD / 2) clk_in = ~clk_in;
    end

    // released on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_in);
        @(negedge clk_in);
        reset = 1'b0;
    end

endmodule

// File: panel_ctrl_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench top: stimulus, watchdog, result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module panel_ctrl_tb;

    localparam int SWEEPS = 4;
    // four 1024-cycle sweeps plus ~40 commands is about 35000 at period 8
    localparam int WATCHDOG_TIME = 60000;

    logic clk_in;
    logic reset;
    panel_pkg::cmd_byte_t data_rx;
    logic data_ready_n;
    logic [2:0] rgb_enable;
    panel_pkg::brightness_t brightness_level;
    panel_pkg::fb_addr_t ram_address;
    panel_pkg::pixel_data_t ram_data;
    logic ram_write_enable;
    logic busy;
    logic ready_for_data;

    tb_clock_gen clock_i (.clk_in(clk_in), .reset(reset));
    panel_ctrl_top dut_i (.*);

    // wait_ready low offers the byte while a sweep runs
    task automatic offer_byte(input panel_pkg::cmd_byte_t value, input bit wait_ready = 1'b1);
        while (wait_ready && !ready_for_data) begin
            @(negedge clk_in);
        end
        data_rx = value;
        data_ready_n = 1'b0;
        @(negedge clk_in);
        data_ready_n = 1'b1;
        repeat ($urandom_range(3, 0)) @(negedge clk_in);
    endtask

    initial begin
        void'($urandom(85));
        data_rx = '0;
        data_ready_n = 1'b1;
        wait (!reset);
        @(negedge clk_in);
        // every colour off, then back on
        for (int c = 'h11; c <= 'h15; c += 2) begin
            offer_byte(8'(c));
        end
        for (int c = 'h10; c <= 'h14; c += 2) begin
            offer_byte(8'(c));
        end
        // all off, all on, then each bit off in turn
        offer_byte(cmd_pkg::BRIGHTNESS_ZERO);
        offer_byte(cmd_pkg::BRIGHTNESS_NINE);
        for (int c = 'h21; c <= 'h28; c++) begin
            offer_byte(8'(c));
        end
        offer_byte(8'h00);
        offer_byte(8'h2a);
        offer_byte(8'hff);
        offer_byte(cmd_pkg::READBRIGHTNESS);
        offer_byte(8'($urandom));
        offer_byte(cmd_pkg::BLANKPANEL);
        offer_byte(cmd_pkg::RED_DISABLE, 1'b0);
        offer_byte(cmd_pkg::FILLPANEL);
        offer_byte(8'($urandom));
        offer_byte(cmd_pkg::BRIGHTNESS_ONE, 1'b0);
        // settings opcodes mixed with unknown bytes
        repeat (10) begin
            offer_byte(8'(8'h10 + $urandom_range(8'h19, 0)));
        end
        offer_byte(cmd_pkg::READBRIGHTNESS);
        offer_byte(8'($urandom));
        offer_byte(cmd_pkg::FILLPANEL);
        offer_byte(8'($urandom));
        offer_byte(cmd_pkg::BLANKPANEL);
        // accepted only once the last sweep is over
        offer_byte(cmd_pkg::GREEN_DISABLE);
        repeat (4) @(negedge clk_in);
        if (dut_i.checker_i.error_count == 0 && dut_i.checker_i.sweep_count == SWEEPS) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "run ended after %0d of %0d sweeps with %0d assertion failures",
                   dut_i.checker_i.sweep_count, SWEEPS, dut_i.checker_i.error_count);
        end
    end

    always @(dut_i.checker_i.error_count) begin
        if (dut_i.checker_i.error_count != 0) begin
            $display("ERRORS FOUND");
            $fatal(1, "an assertion in the bound checker failed");
        end
    end

    initial begin
        #WATCHDOG_TIME;
        $display("ERRORS FOUND");
        $fatal(1, "watchdog timeout, the test did not finish in time");
    end

endmodule

// File: panel_ctrl.f
+incdir+.
panel_pkg.sv
cmd_pkg.sv
cmd_sequencer.sv
settings_regs.sv
panel_fill.sv
panel_ctrl_top.sv
panel_ctrl_checker.sv
tb_clock_gen.sv
panel_ctrl_tb.sv

// File: Makefile
SOURCES := $(filter-out +incdir+%,$(shell cat panel_ctrl.f)) panel_ctrl_consts.svh

obj_dir/Vpanel_ctrl_tb: $(SOURCES) panel_ctrl.f
	verilator --binary --timing --assert --top-module panel_ctrl_tb -f panel_ctrl.f

run: obj_dir/Vpanel_ctrl_tb
	@out="$$(./obj_dir/Vpanel_ctrl_tb +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

.PHONY: run clean
